/* src/icache_pkg.sv */
package icache_pkg;

  //////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int tag_w      = 22;
  localparam int index_w    = 4;
  localparam int offset_w   = 4;
  localparam int byte_w     = 2;
  localparam int num_ways   = 4;
  localparam int num_sets   = 16;
  localparam int line_words = 16;
  localparam int way_w      = 2;
  localparam int age_w      = 2;

  // Controller state codes
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_lookup  = 2'd1;
  localparam logic [1:0] st_refill  = 2'd2;
  localparam logic [1:0] st_install = 2'd3;

  // Fetch address, flat or split into cache fields
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
      logic [byte_w-1:0]   byte_sel;
    } f;
  } fetch_addr_t;

endpackage

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [index_w-1:0]  set_index,
  input  logic [way_w-1:0]    fill_way,
  input  logic [tag_w-1:0]    fill_tag,
  input  logic                tag_we,
  input  logic [tag_w-1:0]    lookup_tag,
  output logic                hit,
  output logic [way_w-1:0]    hit_way,
  output logic [num_ways-1:0] valid_set
);

  logic [tag_w-1:0]    tag_mem [num_ways][num_sets];
  logic [num_ways-1:0] valid_mem [num_sets];
  logic [tag_w-1:0]    tag_q [num_ways];
  logic [num_ways-1:0] match;

  // Tag arrays, read one cycle after the index
  always_ff @(posedge clk)
  begin
    if (tag_we)
      tag_mem[fill_way][set_index] <= fill_tag;
    for (int w = 0; w < num_ways; w++)
      tag_q[w] <= tag_mem[w][set_index];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
        valid_mem[s] <= '0;
      valid_set <= '0;
    end
    else
    begin
      if (tag_we)
        valid_mem[set_index][fill_way] <= 1'b1;
      valid_set <= valid_mem[set_index];
    end
  end

  //////////////////////////////////////////////////
  // Compare and encode
  //////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
      match[w] = valid_set[w] && (tag_q[w] == lookup_tag);
  end

  assign hit = |match;

  // Lowest matching way wins
  always_comb
  begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (match[w])
        hit_way = way_w'(w);
    end
  end

endmodule

/* src/data_store.sv */
`timescale 1ns/1ps

module data_store
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic [index_w-1:0]  set_index,
  input  logic [offset_w-1:0] read_offset,
  input  logic [way_w-1:0]    hit_way,
  input  logic                refill_we,
  input  logic [way_w-1:0]    fill_way,
  input  logic [offset_w-1:0] refill_offset,
  input  logic [data_w-1:0]   refill_data,
  output logic [data_w-1:0]   rd_data
);

  // One word per way, set and offset
  logic [data_w-1:0] line_mem [num_ways][num_sets][line_words];

  //////////////////////////////////////////////////
  // Refill write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (refill_we)
      line_mem[fill_way][set_index][refill_offset] <= refill_data;
  end

  // Read port, hit way picks the line
  always_ff @(posedge clk)
  begin
    rd_data <= line_mem[hit_way][set_index][read_offset];
  end

endmodule

/* src/lru_store.sv */
`timescale 1ns/1ps

module lru_store
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [index_w-1:0]  set_index,
  input  logic [num_ways-1:0] valid_set,
  input  logic                lru_we,
  input  logic [way_w-1:0]    used_way,
  output logic [way_w-1:0]    victim
);

  logic [age_w-1:0] age_mem [num_sets][num_ways];
  logic [age_w-1:0] age_q [num_ways];
  logic [age_w-1:0] age_new [num_ways];
  logic [way_w-1:0] oldest;

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < num_ways; w++)
      age_q[w] <= age_mem[set_index][w];
  end

  //////////////////////////////////////////////////
  // Age update
  //////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      if (way_w'(w) == used_way)
        age_new[w] = '0;
      else if (age_q[w] <= age_q[used_way])
        age_new[w] = age_q[w] + 1'b1;
      else
        age_new[w] = age_q[w];
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
        for (int w = 0; w < num_ways; w++)
          age_mem[s][w] <= '0;
    end
    else if (lru_we)
    begin
      for (int w = 0; w < num_ways; w++)
        age_mem[set_index][w] <= age_new[w];
    end
  end

  //////////////////////////////////////////////////
  // Victim choice
  //////////////////////////////////////////////////
  // Strict compare keeps the lowest way on a tie
  always_comb
  begin
    oldest = '0;
    for (int w = 1; w < num_ways; w++)
    begin
      if (age_q[w] > age_q[oldest])
        oldest = way_w'(w);
    end
  end

  // Any invalid way beats the oldest one
  always_comb
  begin
    victim = oldest;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!valid_set[w])
        victim = way_w'(w);
    end
  end

endmodule

/* src/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  fetch_addr_t         addr,
  output logic                ok,
  output logic                mem_req,
  output logic [addr_w-1:0]   mem_addr,
  input  logic                mem_valid,
  input  logic                hit,
  input  logic [way_w-1:0]    hit_way,
  input  logic [way_w-1:0]    victim,
  output logic [index_w-1:0]  set_index,
  output logic [offset_w-1:0] refill_offset,
  output logic                refill_we,
  output logic [way_w-1:0]    fill_way,
  output logic [tag_w-1:0]    fill_tag,
  output logic                tag_we,
  output logic                lru_we,
  output logic [way_w-1:0]    used_way
);

  logic [1:0]          state;
  logic [1:0]          state_next;
  fetch_addr_t         req_addr;
  fetch_addr_t         line_base;
  logic [offset_w-1:0] beat_cnt;
  logic                accept;
  logic                last_beat;

  // No new request during the ok cycle, addr is still the old one
  assign accept    = (state == st_idle) && req && !ok;
  assign last_beat = mem_valid && (beat_cnt == offset_w'(line_words - 1));

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
        if (accept)
          state_next = st_lookup;
      st_lookup:
        if (hit)
          state_next = st_idle;
        else
          state_next = st_refill;
      st_refill:
        if (last_beat)
          state_next = st_install;
      st_install:
        state_next = st_idle;
      default:
        state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= st_idle;
      ok       <= 1'b0;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      ok    <= (state == st_lookup) && hit;
      // Wraps to zero after the last beat
      if ((state == st_refill) && mem_valid)
        beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      req_addr <= addr;
    if ((state == st_lookup) && !hit)
      fill_way <= victim;
  end

  //////////////////////////////////////////////////
  // Store and memory controls
  //////////////////////////////////////////////////
  assign set_index = (state == st_idle) ? addr.f.index : req_addr.f.index;
  assign fill_tag  = req_addr.f.tag;

  always_comb
  begin
    line_base            = req_addr;
    line_base.f.offset   = '0;
    line_base.f.byte_sel = '0;
  end

  assign mem_addr      = line_base.raw;
  assign mem_req       = (state == st_refill);
  assign refill_we     = (state == st_refill) && mem_valid;
  assign refill_offset = beat_cnt;
  assign tag_we        = (state == st_install);

  // Ages move on the hit that completes an access
  assign lru_we   = (state == st_lookup) && hit;
  assign used_way = hit_way;

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  fetch_addr_t       addr,
  output logic              ok,
  output logic [data_w-1:0] ins,
  output logic              mem_req,
  output logic [addr_w-1:0] mem_addr,
  input  logic              mem_valid,
  input  logic [data_w-1:0] mem_rdata
);

  logic                hit;
  logic [way_w-1:0]    hit_way;
  logic [way_w-1:0]    victim;
  logic [index_w-1:0]  set_index;
  logic [offset_w-1:0] refill_offset;
  logic                refill_we;
  logic [way_w-1:0]    fill_way;
  logic [tag_w-1:0]    fill_tag;
  logic                tag_we;
  logic                lru_we;
  logic [way_w-1:0]    used_way;
  logic [num_ways-1:0] valid_set;

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .addr          (addr),
    .ok            (ok),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_valid     (mem_valid),
    .hit           (hit),
    .hit_way       (hit_way),
    .victim        (victim),
    .set_index     (set_index),
    .refill_offset (refill_offset),
    .refill_we     (refill_we),
    .fill_way      (fill_way),
    .fill_tag      (fill_tag),
    .tag_we        (tag_we),
    .lru_we        (lru_we),
    .used_way      (used_way)
  );

  // Latched request tag doubles as the compare tag
  tag_store u_tags (
    .clk        (clk),
    .rst        (rst),
    .set_index  (set_index),
    .fill_way   (fill_way),
    .fill_tag   (fill_tag),
    .tag_we     (tag_we),
    .lookup_tag (fill_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .valid_set  (valid_set)
  );

  // addr is held by the CPU until ok
  data_store u_data (
    .clk           (clk),
    .set_index     (set_index),
    .read_offset   (addr.f.offset),
    .hit_way       (hit_way),
    .refill_we     (refill_we),
    .fill_way      (fill_way),
    .refill_offset (refill_offset),
    .refill_data   (mem_rdata),
    .rd_data       (ins)
  );

  lru_store u_lru (
    .clk       (clk),
    .rst       (rst),
    .set_index (set_index),
    .valid_set (valid_set),
    .lru_we    (lru_we),
    .used_way  (used_way),
    .victim    (victim)
  );

endmodule

/* test/mem_model.sv */
`timescale 1ns/1ps

// Burst responder for the cache refill port
module mem_model
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_req,
  input  logic [addr_w-1:0] mem_addr,
  input  logic              stall,
  output logic              mem_valid,
  output logic [addr_w-1:0] beat_addr
);

  int beats_sent;

  //////////////////////////////////////////////////
  // Beat generation
  //////////////////////////////////////////////////
  // One beat per cycle 2 ns after the edge, none while stalled
  initial
  begin
    mem_valid  = 1'b0;
    beat_addr  = '0;
    beats_sent = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (rst || !mem_req)
      begin
        mem_valid  = 1'b0;
        beats_sent = 0;
      end
      else if (!stall && (beats_sent < line_words))
      begin
        mem_valid  = 1'b1;
        // Words leave in order 0 to 15 from the line base
        beat_addr  = mem_addr + (addr_w'(beats_sent) << byte_w);
        beats_sent++;
      end
      else
      begin
        mem_valid = 1'b0;
      end
    end
  end

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam logic [31:0] seed = 32'd27;
  localparam int num_directed = 30;
  localparam int num_random = 60;
  localparam int access_cycles = 200;
  localparam int watchdog_cycles = (num_directed + num_random) * 40 + 100;
  localparam logic [tag_w-1:0] evict_base = 22'h0002a0;

  logic              clk = 1'b0;
  logic              rst;
  logic              req;
  fetch_addr_t       addr;
  logic              ok;
  logic [data_w-1:0] ins;
  logic              mem_req;
  logic [addr_w-1:0] mem_addr;
  logic              mem_valid;
  logic [data_w-1:0] mem_rdata;
  logic [addr_w-1:0] beat_addr;
  logic              stall;
  logic [31:0]       rng;
  logic [31:0]       stall_rng;
  logic              exp_hit;
  int                wait_cnt;
  int                beat_count;
  logic              refill_seen;

  // Reference cache state
  logic [tag_w-1:0] ref_tag [num_sets][num_ways];
  logic             ref_valid [num_sets][num_ways];
  int               ref_age [num_sets][num_ways];

  always #20 clk = ~clk;

  icache_top dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .addr      (addr),
    .ok        (ok),
    .ins       (ins),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_rdata (mem_rdata)
  );

  mem_model mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .stall     (stall),
    .mem_valid (mem_valid),
    .beat_addr (beat_addr)
  );

  assign mem_rdata = word_pattern(beat_addr);

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory contents as a function of the word address
  function automatic logic [data_w-1:0] word_pattern(input logic [addr_w-1:0] a);
    logic [addr_w-1:0] w;
    w = a >> byte_w;
    return {w[15:0], ~w[29:14]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [addr_w-1:0] line_base(input logic [addr_w-1:0] a);
    return (a >> (offset_w + byte_w)) << (offset_w + byte_w);
  endfunction

  function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
                                                  input logic [index_w-1:0] index,
                                                  input logic [offset_w-1:0] offset);
    fetch_addr_t a;
    a.f.tag      = tag;
    a.f.index    = index;
    a.f.offset   = offset;
    a.f.byte_sel = '0;
    return a.raw;
  endfunction

  // Lowest invalid way, else the oldest with ties to the lowest way
  function automatic int pick_victim(input logic [index_w-1:0] idx);
    int v;
    v = -1;
    for (int w = num_ways - 1; w >= 0; w--)
      if (!ref_valid[idx][w])
        v = w;
    if (v < 0)
    begin
      v = 0;
      for (int w = 1; w < num_ways; w++)
        if (ref_age[idx][w] > ref_age[idx][v])
          v = w;
    end
    return v;
  endfunction

  function automatic void touch_way(input logic [index_w-1:0] idx, input int way);
    int used_age;
    used_age = ref_age[idx][way];
    for (int w = 0; w < num_ways; w++)
    begin
      if (w == way)
        ref_age[idx][w] = 0;
      else if (ref_age[idx][w] <= used_age)
        ref_age[idx][w]++;
    end
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  // One CPU fetch, starting in the cycle after the previous ok
  task automatic fetch(input logic [addr_w-1:0] a);
    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tg;
    int                 way;
    int                 waited;
    @(posedge clk);
    #2;
    rng = xorshift(rng);
    if (rng[4:3] == 2'd0)
    begin
      req = 1'b0;
      @(posedge clk);
      #2;
    end
    idx = a[offset_w+byte_w +: index_w];
    tg  = a[addr_w-1 -: tag_w];
    way = -1;
    for (int w = num_ways - 1; w >= 0; w--)
      if (ref_valid[idx][w] && (ref_tag[idx][w] == tg))
        way = w;
    exp_hit = (way >= 0);
    if (way < 0)
    begin
      way = pick_victim(idx);
      ref_valid[idx][way] = 1'b1;
      ref_tag[idx][way]   = tg;
    end
    touch_way(idx, way);
    req      = 1'b1;
    addr.raw = a;
    waited   = 0;
    while (!ok)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > access_cycles)
        stop_run($sformatf("No ok within %0d cycles for address %h", access_cycles, a));
    end
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wait_cnt    <= 0;
      beat_count  <= 0;
      refill_seen <= 1'b0;
    end
    else
    begin
      wait_cnt <= (req && !ok) ? wait_cnt + 1 : 0;
      if (mem_req && mem_valid)
        beat_count <= beat_count + 1;
      else if (!mem_req)
        beat_count <= 0;
      if (ok)
        refill_seen <= 1'b0;
      else if (mem_req)
        refill_seen <= 1'b1;
    end
  end

  chk_ins: assert property (@(posedge clk) disable iff (rst)
    ok |-> ins == word_pattern(addr.raw))
    else report_mismatch("ins", $sampled(ins), word_pattern($sampled(addr.raw)));

  chk_hit_latency: assert property (@(posedge clk) disable iff (rst)
    ok && exp_hit |-> wait_cnt == 2)
    else report_mismatch("hit ok latency", $sampled(wait_cnt), 2);

  chk_hit_miss: assert property (@(posedge clk) disable iff (rst)
    ok |-> refill_seen == !exp_hit)
    else stop_run($sformatf("Refill behavior at %0t disagrees with the model for address %h",
                            $time, $sampled(addr.raw)));

  chk_mem_addr: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> mem_addr == line_base(addr.raw))
    else report_mismatch("mem_addr", $sampled(mem_addr), line_base($sampled(addr.raw)));

  chk_beats: assert property (@(posedge clk) disable iff (rst)
    $fell(mem_req) |-> beat_count == line_words)
    else report_mismatch("refill beats", $sampled(beat_count), line_words);

  chk_ok_req: assert property (@(posedge clk) disable iff (rst) ok |-> req)
    else stop_run("ok pulsed while req was low");

  chk_mem_req: assert property (@(posedge clk) disable iff (rst) $rose(mem_req) |-> req)
    else stop_run("mem_req rose with no pending request");

  chk_reset: assert property (@(posedge clk) rst |-> !ok && !mem_req)
    else stop_run("ok or mem_req high during reset");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial
  begin
    stall_rng = xorshift(seed);
    stall     = 1'b0;
    forever
    begin
      @(negedge clk);
      stall_rng = xorshift(stall_rng);
      stall     = (stall_rng[2:0] < 3'd3);
    end
  end

  initial
  begin
    rst      = 1'b1;
    req      = 1'b0;
    addr.raw = '0;
    exp_hit  = 1'b0;
    rng      = seed;
    for (int s = 0; s < num_sets; s++)
      for (int w = 0; w < num_ways; w++)
      begin
        ref_tag[s][w]   = '0;
        ref_valid[s][w] = 1'b0;
        ref_age[s][w]   = 0;
      end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // Cold miss, then walk the new line
    fetch(make_addr(22'h0001f3, 4'd3, 4'd5));
    for (int o = 0; o < line_words; o++)
      fetch(make_addr(22'h0001f3, 4'd3, offset_w'(o)));

    // Fill set 9, re-touch all but the third line, then bring in a fifth
    for (int t = 0; t < 4; t++)
      fetch(make_addr(evict_base + tag_w'(t), 4'd9, 4'd0));
    fetch(make_addr(evict_base, 4'd9, 4'd1));
    fetch(make_addr(evict_base + 22'd1, 4'd9, 4'd2));
    fetch(make_addr(evict_base + 22'd3, 4'd9, 4'd3));
    fetch(make_addr(evict_base + 22'd4, 4'd9, 4'd4));
    fetch(make_addr(evict_base, 4'd9, 4'd6));
    fetch(make_addr(evict_base + 22'd1, 4'd9, 4'd7));
    fetch(make_addr(evict_base + 22'd3, 4'd9, 4'd8));
    fetch(make_addr(evict_base + 22'd4, 4'd9, 4'd9));
    fetch(make_addr(evict_base + 22'd2, 4'd9, 4'd10));

    // Small tag pool so hits and evictions mix
    for (int i = 0; i < num_random; i++)
    begin
      rng = xorshift(rng);
      fetch(make_addr(tag_w'(rng[18:16] % 3'd6), rng[9:6], rng[13:10]));
    end

    @(posedge clk);
    #2;
    req = 1'b0;
    repeat (3) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_run("Watchdog expired before all accesses finished");
  end

endmodule

/* sim.f */
src/icache_pkg.sv
src/tag_store.sv
src/data_store.sv
src/lru_store.sv
src/icache_ctrl.sv
src/icache_top.sv
test/mem_model.sv
test/icache_tb.sv

/* Makefile */
# Verilator flow for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Echo the run output and fail unless the pass line shows up
sim: build
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } index($$0, "$(PASS_MSG)") { found = 1 } \
		END { exit !found }'

clean:
	rm -rf $(BUILD_DIR)
